/* Makefile */
# Verilator build and run for the execute core testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_core
RTL_TOP   ?= exec_core
FILELIST  ?= exec_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= All checks passed

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter hw/%,$(SRCS))
HDRS     := $(wildcard include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) +incdir+include $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* exec_core.f */
+incdir+include
hw/exec_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/operand_bypass.sv
hw/alu.sv
hw/mul_unit.sv
hw/exec_pipeline.sv
hw/exec_core.sv
tb/tb_exec_core.sv

/* hw/alu.sv */
`timescale 1ns/1ns
`include "exec_core_macros.svh"

module alu (
    input  exec_pkg::alu_op_e op_i,
    input  logic [`XLEN-1:0]  a_i,
    input  logic [`XLEN-1:0]  b_i,
    output logic [`XLEN-1:0]  result_o
);

    // One subtractor for SUB, SLT and SLTU, top bit is the borrow
    logic [`XLEN:0] diff;
    logic           lt_signed;

    assign diff = {1'b0, a_i} - {1'b0, b_i};

    // Sign bits decide when they differ
    assign lt_signed = (a_i[`XLEN-1] != b_i[`XLEN-1]) ? a_i[`XLEN-1] : diff[`XLEN-1];

    always_comb begin
        case (op_i)
            exec_pkg::ALU_ADD:  result_o = a_i + b_i;
            exec_pkg::ALU_SUB:  result_o = diff[`XLEN-1:0];
            exec_pkg::ALU_SLT:  result_o = {{(`XLEN-1){1'b0}}, lt_signed};
            exec_pkg::ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, diff[`XLEN]};
            exec_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            exec_pkg::ALU_OR:   result_o = a_i | b_i;
            exec_pkg::ALU_AND:  result_o = a_i & b_i;
            default:            result_o = a_i + b_i;
        endcase
    end

endmodule

/* hw/exec_core.sv */
`timescale 1ns/1ns
`include "exec_core_macros.svh"

module exec_core (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              instr_valid_i,
    input  exec_pkg::instr_u  instr_i,
    output logic              instr_ready_o,
    output logic              commit_valid_o,
    output exec_pkg::commit_t commit_o
);

    exec_pkg::decoded_t     decoded;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    instr_decoder u_decoder (
        .instr_i   (instr_i),
        .decoded_o (decoded)
    );

    // Written back by the commit strobe
    reg_file u_regs (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (commit_valid_o),
        .wr_i       (commit_o)
    );

    exec_pipeline u_pipeline (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .valid_i        (instr_valid_i),
        .decoded_i      (decoded),
        .ready_o        (instr_ready_o),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

/* hw/exec_pipeline.sv */
`timescale 1ns/1ns
`include "exec_core_macros.svh"

module exec_pipeline (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   valid_i,
    input  exec_pkg::decoded_t     decoded_i,
    output logic                   ready_o,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    output logic                   commit_valid_o,
    output exec_pkg::commit_t      commit_o
);

    typedef struct packed {
        logic                   pending;
        logic [`REG_ADDR_W-1:0] rd;
        exec_pkg::func_unit_e   sel;
        logic [`XLEN-1:0]       data;
    } stage_t;

    logic               de_ex_valid_q;
    exec_pkg::decoded_t de_ex_q;
    logic               issue;

    stage_t           ex1_q;
    stage_t           ex1_d;
    stage_t           ex2_q;
    stage_t           ex2_d;
    logic             ex1_data_valid;
    logic [`XLEN-1:0] ex1_data;
    logic             ex2_data_valid;
    logic [`XLEN-1:0] ex2_data;
    logic             ex2_ready;

    logic             data_hazard;
    logic [`XLEN-1:0] ex_rs1;
    logic [`XLEN-1:0] ex_rs2;
    logic [`XLEN-1:0] alu_result;
    logic             mul_ready;
    logic             mul_valid;
    logic [`XLEN-1:0] mul_result;

    //////////////////////////////
    // DE-EX register
    //////////////////////////////

    assign ready_o = !de_ex_valid_q || issue;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            de_ex_valid_q <= 1'b0;
        end else if (valid_i && ready_o) begin
            de_ex_valid_q <= 1'b1;
        end else if (issue) begin
            de_ex_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            de_ex_q <= decoded_i;
        end
    end

    // Register file reads from the held sources
    assign rs1_addr_o = de_ex_q.rs1;
    assign rs2_addr_o = de_ex_q.rs2;

    //////////////////////////////
    // Issue and execute
    //////////////////////////////

    operand_bypass u_bypass (
        .decoded_i     (de_ex_q),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .ex1_pending_i (ex1_q.pending),
        .ex1_valid_i   (ex1_data_valid),
        .ex2_pending_i (ex2_q.pending),
        .ex2_valid_i   (ex2_data_valid),
        .ex1_rd_i      (ex1_q.rd),
        .ex2_rd_i      (ex2_q.rd),
        .ex1_data_i    (ex1_data),
        .ex2_data_i    (ex2_data),
        .rs1_o         (ex_rs1),
        .rs2_o         (ex_rs2),
        .data_hazard_o (data_hazard)
    );

    alu u_alu (
        .op_i     (de_ex_q.op),
        .a_i      (ex_rs1),
        .b_i      (de_ex_q.use_imm ? de_ex_q.imm : ex_rs2),
        .result_o (alu_result)
    );

    mul_unit u_mul (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .start_i  (issue && de_ex_q.unit == exec_pkg::FU_MUL),
        .a_i      (ex_rs1),
        .b_i      (ex_rs2),
        .ready_o  (mul_ready),
        .valid_o  (mul_valid),
        .result_o (mul_result)
    );

    assign ex2_ready = !ex2_q.pending || ex2_data_valid;

    // EX1 must drain this cycle, and a busy multiplier blocks MUL
    assign issue = de_ex_valid_q && !data_hazard && (!ex1_q.pending || ex2_ready) &&
                   (de_ex_q.unit != exec_pkg::FU_MUL || mul_ready);

    //////////////////////////////
    // EX1 and EX2 stages
    //////////////////////////////

    // A multiplier valid seen by EX2 belongs to EX2
    assign ex1_data_valid = (ex1_q.sel == exec_pkg::FU_ALU) ||
                            (mul_valid && ex2_q.sel != exec_pkg::FU_MUL);
    assign ex1_data = (ex1_q.sel == exec_pkg::FU_ALU) ? ex1_q.data : mul_result;
    assign ex2_data_valid = (ex2_q.sel == exec_pkg::FU_ALU) || mul_valid;
    assign ex2_data = (ex2_q.sel == exec_pkg::FU_ALU) ? ex2_q.data : mul_result;

    always_comb begin
        ex1_d = ex1_q;
        // Fold a finished result so it no longer depends on the unit
        if (ex1_data_valid) begin
            ex1_d.sel = exec_pkg::FU_ALU;
            ex1_d.data = ex1_data;
        end
        if (ex2_ready) begin
            ex1_d.pending = 1'b0;
            ex1_d.sel = exec_pkg::FU_ALU;
        end
        if (issue) begin
            ex1_d.pending = 1'b1;
            ex1_d.rd = de_ex_q.rd;
            ex1_d.sel = de_ex_q.unit;
            ex1_d.data = alu_result;
        end
    end

    always_comb begin
        ex2_d = ex2_q;
        if (ex2_data_valid) begin
            ex2_d.pending = 1'b0;
            ex2_d.sel = exec_pkg::FU_ALU;
        end
        if (ex1_q.pending && ex2_ready) begin
            ex2_d.pending = 1'b1;
            ex2_d.rd = ex1_q.rd;
            ex2_d.sel = ex1_data_valid ? exec_pkg::FU_ALU : ex1_q.sel;
            ex2_d.data = ex1_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_q <= '0;
            ex2_q <= '0;
        end else begin
            ex1_q <= ex1_d;
            ex2_q <= ex2_d;
        end
    end

    // Write-back strobe
    assign commit_valid_o = ex2_q.pending && ex2_data_valid;
    assign commit_o.rd = ex2_q.rd;
    assign commit_o.data = ex2_data;

endmodule

/* hw/exec_pkg.sv */
`include "exec_core_macros.svh"

package exec_pkg;

    // R-type view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // I-type view of an instruction word
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Unit that supplies a stage's result
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } func_unit_e;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        alu_op_e                op;
        logic                   use_imm;
        logic [`XLEN-1:0]       imm;
        func_unit_e             unit;
    } decoded_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } commit_t;

endpackage

/* hw/instr_decoder.sv */
`timescale 1ns/1ns
`include "exec_core_macros.svh"

module instr_decoder (
    input  exec_pkg::instr_u   instr_i,
    output exec_pkg::decoded_t decoded_o
);

    exec_pkg::alu_op_e f3_op;
    logic              f3_ok;

    // funct3 sits at the same place in both views
    always_comb begin
        f3_ok = 1'b1;
        f3_op = exec_pkg::ALU_ADD;
        case (instr_i.r_fmt.funct3)
            `F3_ADD:  f3_op = exec_pkg::ALU_ADD;
            `F3_SLT:  f3_op = exec_pkg::ALU_SLT;
            `F3_SLTU: f3_op = exec_pkg::ALU_SLTU;
            `F3_XOR:  f3_op = exec_pkg::ALU_XOR;
            `F3_OR:   f3_op = exec_pkg::ALU_OR;
            `F3_AND:  f3_op = exec_pkg::ALU_AND;
            default:  f3_ok = 1'b0;
        endcase
    end

    always_comb begin
        // No-op unless a supported encoding matches: x0 <= x0 + 0
        decoded_o = '0;
        decoded_o.op = exec_pkg::ALU_ADD;
        decoded_o.use_imm = 1'b1;
        decoded_o.unit = exec_pkg::FU_ALU;

        case (instr_i.r_fmt.opcode)
            `OPC_OP: begin
                if ((instr_i.r_fmt.funct7 == 7'd0 && f3_ok) ||
                    (instr_i.r_fmt.funct3 == `F3_ADD &&
                     (instr_i.r_fmt.funct7 == `FUNCT7_SUB ||
                      instr_i.r_fmt.funct7 == `FUNCT7_MULDIV))) begin
                    decoded_o.rs1 = instr_i.r_fmt.rs1;
                    decoded_o.rs2 = instr_i.r_fmt.rs2;
                    decoded_o.rd = instr_i.r_fmt.rd;
                    decoded_o.use_imm = 1'b0;
                    decoded_o.op = f3_op;
                    if (instr_i.r_fmt.funct7 == `FUNCT7_SUB) begin
                        decoded_o.op = exec_pkg::ALU_SUB;
                    end
                    if (instr_i.r_fmt.funct7 == `FUNCT7_MULDIV) begin
                        decoded_o.unit = exec_pkg::FU_MUL;
                    end
                end
            end
            `OPC_OP_IMM: begin
                if (f3_ok) begin
                    decoded_o.rs1 = instr_i.i_fmt.rs1;
                    decoded_o.rd = instr_i.i_fmt.rd;
                    decoded_o.op = f3_op;
                    decoded_o.imm = {{(`XLEN-12){instr_i[`INSTR_W-1]}}, instr_i.i_fmt.imm};
                end
            end
            default: ;
        endcase
    end

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/1ns
`include "exec_core_macros.svh"

module mul_unit (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             start_i,
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    output logic             ready_o,
    output logic             valid_o,
    output logic [`XLEN-1:0] result_o
);

    // Multiplier bits consumed per step
    localparam int STEP_W = `XLEN / `MUL_CYCLES;
    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic [`XLEN-1:0] a_q;
    logic [`XLEN-1:0] b_q;
    logic [`XLEN-1:0] acc_q;
    logic [`XLEN-1:0] acc_d;
    logic [CNT_W-1:0] cnt_q;
    logic             done_q;

    // Shift-and-add over the low STEP_W bits of the multiplier
    always_comb begin
        acc_d = acc_q;
        for (int j = 0; j < STEP_W; j++) begin
            if (b_q[j]) begin
                acc_d = acc_d + (a_q << j);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
            done_q <= 1'b0;
        end else if (start_i) begin
            cnt_q <= CNT_W'(`MUL_CYCLES);
            done_q <= 1'b0;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
            done_q <= (cnt_q == CNT_W'(1));
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q <= a_i;
            b_q <= b_i;
            acc_q <= '0;
        end else if (cnt_q != '0) begin
            acc_q <= acc_d;
            a_q <= a_q << STEP_W;
            b_q <= b_q >> STEP_W;
        end
    end

    // Result held until the next start
    assign ready_o = (cnt_q == '0);
    assign valid_o = done_q;
    assign result_o = acc_q;

endmodule

/* hw/operand_bypass.sv */
`timescale 1ns/1ns
`include "exec_core_macros.svh"

module operand_bypass (
    input  exec_pkg::decoded_t     decoded_i,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    input  logic                   ex1_pending_i,
    input  logic                   ex1_valid_i,
    input  logic                   ex2_pending_i,
    input  logic                   ex2_valid_i,
    input  logic [`REG_ADDR_W-1:0] ex1_rd_i,
    input  logic [`REG_ADDR_W-1:0] ex2_rd_i,
    input  logic [`XLEN-1:0]       ex1_data_i,
    input  logic [`XLEN-1:0]       ex2_data_i,
    output logic [`XLEN-1:0]       rs1_o,
    output logic [`XLEN-1:0]       rs2_o,
    output logic                   data_hazard_o
);

    logic rs1_hazard;
    logic rs2_hazard;

    // Returns {hazard, operand} for one source register
    function automatic logic [`XLEN:0] forward(input logic [`REG_ADDR_W-1:0] src,
                                               input logic [`XLEN-1:0]       rf_data);
        logic [`XLEN:0] res;
        res = {1'b0, rf_data};
        if (src != '0 && ex2_pending_i && ex2_rd_i == src) begin
            res = {!ex2_valid_i, ex2_data_i};
        end
        // EX1 holds the younger producer so it wins
        if (src != '0 && ex1_pending_i && ex1_rd_i == src) begin
            res = {!ex1_valid_i, ex1_data_i};
        end
        return res;
    endfunction

    always_comb begin
        {rs1_hazard, rs1_o} = forward(decoded_i.rs1, rs1_data_i);
        {rs2_hazard, rs2_o} = forward(decoded_i.rs2, rs2_data_i);
    end

    assign data_hazard_o = rs1_hazard || rs2_hazard;

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns
`include "exec_core_macros.svh"

module reg_file (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    input  logic                   wr_en_i,
    input  exec_pkg::commit_t      wr_i
);

    // x1 to x31, x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs <= '{default: '0};
        end else if (wr_en_i && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* include/exec_core_macros.svh */
`ifndef EXEC_CORE_MACROS_SVH
`define EXEC_CORE_MACROS_SVH

// Widths
`define XLEN          32
`define REG_ADDR_W    5
`define NUM_REGS      32
`define INSTR_W       32

// Major opcodes
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011

// funct7 selectors for the OP opcode
`define FUNCT7_SUB    7'b0100000
`define FUNCT7_MULDIV 7'b0000001

// funct3 encodings shared by OP and OP-IMM
`define F3_ADD        3'b000
`define F3_SLT        3'b010
`define F3_SLTU       3'b011
`define F3_XOR        3'b100
`define F3_OR         3'b110
`define F3_AND        3'b111

// Multiplier latency from acceptance to valid
`define MUL_CYCLES    4

`endif

/* tb/exec_core_cases.txt */
// Columns: instruction word, expected commit rd, expected commit data (all hex)
// Cases run in program order, so later cases read registers written by earlier ones
00500093 01 00000005
FFD00113 02 FFFFFFFD
002081B3 03 00000002
40208233 04 00000008
001122B3 05 00000001
00113333 06 00000000
0020C3B3 07 FFFFFFF8
0020E433 08 FFFFFFFD
0020F4B3 09 00000005
FFE12513 0A 00000001
FFF0B593 0B 00000001
0F00C613 0C 000000F5
1001E693 0D 00000102
7FF3F713 0E 000007F8
022087B3 0F FFFFFFF1
00178833 10 FFFFFFF6
02F788B3 11 000000E1
00708013 00 0000000C
123450B7 00 00000000
00100933 12 00000005

/* tb/tb_exec_core.sv */
`timescale 1ns/1ns
`include "exec_core_macros.svh"

module tb_exec_core;

    localparam int MAX_CASES = 64;
    localparam int CLK_PERIOD = 100;

    logic              clk_i;
    logic              rst_ni;
    logic              instr_valid_i;
    exec_pkg::instr_u  instr_i;
    logic              instr_ready_o;
    logic              commit_valid_o;
    exec_pkg::commit_t commit_o;

    // Three words per case for instruction, rd and data
    logic [31:0] cases_mem [0:3*MAX_CASES-1];

    int          num_cases = 0;
    int          accepted_count = 0;
    int          commit_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    logic        stall_seen = 1'b0;
    logic        cases_loaded = 1'b0;
    logic [31:0] lcg_state;

    exec_core uut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[31:16]};
    endfunction

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic load_cases();
        // Rows past the end of the file keep an rd word with the top half set
        for (int i = 0; i < 3 * MAX_CASES; i++) begin
            cases_mem[i] = 32'hFFFF_0000 | 32'(i);
        end
        $readmemh("tb/exec_core_cases.txt", cases_mem);
        while (num_cases < MAX_CASES && cases_mem[3*num_cases+1][31:16] != 16'hFFFF) begin
            num_cases++;
        end
        cases_loaded = 1'b1;
    endtask

    // Holds the word until the handshake completes and returns on a falling edge
    task automatic send_word(input logic [31:0] word);
        logic ready_seen;
        instr_valid_i = 1'b1;
        instr_i = word;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            ready_seen = instr_ready_o;
            @(negedge clk_i);
        end
    endtask

    task automatic check_idle(input string phase);
        check_count += 2;
        if (commit_valid_o) begin
            $display("MISMATCH %s commit_valid_o: expected 0x0, got 0x%h",
                     phase, commit_valid_o);
            error_count++;
        end
        if (!instr_ready_o) begin
            $display("MISMATCH %s instr_ready_o: expected 0x1, got 0x%h",
                     phase, instr_ready_o);
            error_count++;
        end
    endtask

    //////////////////////////////
    // Commit monitor
    //////////////////////////////

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (instr_valid_i && instr_ready_o) begin
                accepted_count <= accepted_count + 1;
            end
            if (!instr_ready_o) begin
                stall_seen <= 1'b1;
            end
        end
    end

    task automatic check_commit();
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic        ok;
        if (commit_count >= accepted_count || commit_count >= num_cases) begin
            $display("Commit of rd %0d arrived with no accepted word left to match it",
                     commit_o.rd);
            error_count++;
        end else begin
            exp_rd = cases_mem[3*commit_count+1][4:0];
            exp_data = cases_mem[3*commit_count+2];
            ok = 1'b1;
            check_count += 2;
            if (commit_o.rd != exp_rd) begin
                $display("MISMATCH case %0d commit_o.rd: expected 0x%h, got 0x%h",
                         commit_count, exp_rd, commit_o.rd);
                ok = 1'b0;
                error_count++;
            end
            if (commit_o.data != exp_data) begin
                $display("MISMATCH case %0d commit_o.data: expected 0x%h, got 0x%h",
                         commit_count, exp_data, commit_o.data);
                ok = 1'b0;
                error_count++;
            end
            if (ok) begin
                $display("case %0d ok: x%0d = 0x%h", commit_count, exp_rd, exp_data);
            end else begin
                $display("case %0d wrong", commit_count);
            end
        end
        commit_count++;
    endtask

    always @(negedge clk_i) begin
        if (rst_ni && commit_valid_o) begin
            check_commit();
        end
    end

    //////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////

    initial begin
        int gap;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        lcg_state = 32'h64e1;
        load_cases();
        if (num_cases == 0) begin
            $display("No cases were read from tb/exec_core_cases.txt");
            error_count++;
        end

        repeat (3) begin
            @(negedge clk_i);
            check_idle("reset");
        end
        rst_ni = 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            check_idle("idle after reset");
        end

        // Random idle cycles ahead of each word
        for (int k = 0; k < num_cases; k++) begin
            gap = int'(next_rand() % 3);
            if (gap > 0) begin
                instr_valid_i = 1'b0;
                repeat (gap) @(negedge clk_i);
            end
            send_word(cases_mem[3*k]);
        end
        instr_valid_i = 1'b0;

        wait (commit_count >= num_cases);
        // Leave room for a stray duplicate commit
        repeat (4) @(negedge clk_i);

        check_count += 2;
        if (commit_count != accepted_count) begin
            $display("Saw %0d commits for %0d accepted words", commit_count, accepted_count);
            error_count++;
        end
        if (!stall_seen) begin
            $display("instr_ready_o never went low, so no hazard stall was exercised");
            error_count++;
        end

        $display("Summary: %0d cases, %0d checks, %0d errors",
                 num_cases, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        int limit_ns;
        wait (cases_loaded);
        limit_ns = num_cases * (`MUL_CYCLES + 6) * CLK_PERIOD + 2000;
        #(limit_ns);
        $display("Timeout after %0d ns with %0d of %0d expected commits never arrived",
                 limit_ns, num_cases - commit_count, num_cases);
        $display("Checks failed");
        $finish;
    end

endmodule
